// File: design/ex_pkg.sv
`default_nettype none

package ex_pkg;

   localparam int xlen       = 32;
   localparam int ghsr_width = 8;   // Gshare global history length

   // ALU operations
   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_sll,
      alu_slt,
      alu_sltu,
      alu_xor,
      alu_srl,
      alu_sra,
      alu_or,
      alu_and,
      alu_pass_b   // LUI
   } alu_op_e;

   typedef enum logic [2:0] {
      br_eq,
      br_ne,
      br_lt,
      br_ge,
      br_ltu,
      br_geu
   } br_cond_e;

   // Same encoding as the decode stage forwarding unit
   typedef enum logic [1:0] {
      fwd_reg         = 2'b00,
      fwd_from_mem_wb = 2'b01,
      fwd_from_ex_mem = 2'b10
   } fwd_sel_e;

   typedef enum logic [1:0] {
      mem_byte,
      mem_half,
      mem_word
   } mem_size_e;

   typedef struct packed {
      alu_op_e         alu_op;
      logic            alu_src_imm;   // Second operand from immediate
      logic            is_auipc;
      logic            is_branch;
      br_cond_e        br_cond;
      logic            is_jump;       // JAL
      logic            is_jumpr;      // JALR
      logic            mem_read;
      logic            mem_write;
      mem_size_e       mem_size;
      logic            load_unsigned;
      logic [4:0]      rd_addr;
      logic            rd_write;
   } ex_ctrl_t;

   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [xlen-1:0] rs1_data;
      logic [xlen-1:0] rs2_data;
      logic [xlen-1:0] imm;
      ex_ctrl_t        ctrl;
      fwd_sel_e        fwd_sel_rs1;
      fwd_sel_e        fwd_sel_rs2;
   } ex_op_t;

   typedef struct packed {
      logic                  pred_taken;
      logic [xlen-1:0]       pred_target;
      logic [ghsr_width-1:0] ghsr;   // History at prediction time
   } br_pred_t;

   typedef struct packed {
      ex_ctrl_t        ctrl;
      logic [xlen-1:0] rd_data;
      logic [xlen-1:0] mem_addr;
      logic [xlen-1:0] store_data;
      logic [3:0]      byte_en;
      logic            misaligned;
   } ex_result_t;

   typedef struct packed {
      logic                  valid;
      logic                  taken;
      logic                  mispredict;
      logic [xlen-1:0]       branch_pc;
      logic [xlen-1:0]       target;
      logic                  update_ghsr;
      logic [ghsr_width-1:0] ghsr_restore;
   } br_redirect_t;

endpackage

`default_nettype wire

// File: design/ex_operand_sel.sv
`default_nettype none

module ex_operand_sel (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire ex_pkg::ex_op_t         op,
   input  wire logic [ex_pkg::xlen-1:0] fwd_ex_mem,
   input  wire logic [ex_pkg::xlen-1:0] fwd_mem_wb,
   output logic [ex_pkg::xlen-1:0]      rs1_val,
   output logic [ex_pkg::xlen-1:0]      rs2_val,
   output logic [ex_pkg::xlen-1:0]      alu_a,
   output logic [ex_pkg::xlen-1:0]      alu_b
);
   import ex_pkg::*;

   function automatic logic [xlen-1:0] fwd_mux(
      input fwd_sel_e        sel,
      input logic [xlen-1:0] rf_val,
      input logic [xlen-1:0] mem_wb_val,
      input logic [xlen-1:0] ex_mem_val
   );
      case (sel)
         fwd_from_mem_wb: return mem_wb_val;
         fwd_from_ex_mem: return ex_mem_val;   // Youngest producer wins
         default:         return rf_val;
      endcase
   endfunction

   assign rs1_val = fwd_mux(op.fwd_sel_rs1, op.rs1_data, fwd_mem_wb, fwd_ex_mem);
   assign rs2_val = fwd_mux(op.fwd_sel_rs2, op.rs2_data, fwd_mem_wb, fwd_ex_mem);

   assign alu_a = op.ctrl.is_auipc ? op.pc : rs1_val;
   assign alu_b = op.ctrl.alu_src_imm ? op.imm : rs2_val;

   // Decode must never hand over the unused select code
   a_fwd_sel_legal: assert property (@(posedge clk) disable iff (rst)
      (op.fwd_sel_rs1 inside {fwd_reg, fwd_from_mem_wb, fwd_from_ex_mem}) &&
      (op.fwd_sel_rs2 inside {fwd_reg, fwd_from_mem_wb, fwd_from_ex_mem}));

endmodule

`default_nettype wire

// File: design/ex_alu.sv
`default_nettype none

module ex_alu (
   input  wire ex_pkg::alu_op_e         op,
   input  wire logic [ex_pkg::xlen-1:0] a,
   input  wire logic [ex_pkg::xlen-1:0] b,
   output logic [ex_pkg::xlen-1:0]      result
);
   import ex_pkg::*;

   logic [4:0] shamt;

   assign shamt = b[4:0];   // RV32I uses five shift bits

   always_comb begin
      case (op)
         alu_add:    result = a + b;
         alu_sub:    result = a - b;
         alu_sll:    result = a << shamt;
         alu_slt: begin
            result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
         end
         alu_sltu: begin
            result = {{(xlen-1){1'b0}}, a < b};
         end
         alu_xor:    result = a ^ b;
         alu_srl:    result = a >> shamt;
         alu_sra:    result = $signed(a) >>> shamt;
         alu_or:     result = a | b;
         alu_and:    result = a & b;
         alu_pass_b: result = b;   // LUI immediate already shifted by decode
         default:    result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: design/ex_branch_unit.sv
`default_nettype none

module ex_branch_unit (
   input  wire ex_pkg::ex_ctrl_t          ctrl,
   input  wire logic [ex_pkg::xlen-1:0]   pc,
   input  wire logic [ex_pkg::xlen-1:0]   imm,
   input  wire logic [ex_pkg::xlen-1:0]   rs1_val,
   input  wire logic [ex_pkg::xlen-1:0]   rs2_val,
   input  wire ex_pkg::br_pred_t          pred,
   output logic                           taken,
   output logic [ex_pkg::xlen-1:0]        link_pc,
   output logic [ex_pkg::xlen-1:0]        target,
   output logic                           mispredict,
   output logic                           update_ghsr,
   output logic [ex_pkg::ghsr_width-1:0]  ghsr_restore
);
   import ex_pkg::*;

   logic            cond_true;
   logic            is_cf;
   logic [xlen-1:0] jalr_sum;

   always_comb begin
      case (ctrl.br_cond)
         br_eq:   cond_true = (rs1_val == rs2_val);
         br_ne:   cond_true = (rs1_val != rs2_val);
         br_lt:   cond_true = ($signed(rs1_val) < $signed(rs2_val));
         br_ge:   cond_true = ($signed(rs1_val) >= $signed(rs2_val));
         br_ltu:  cond_true = (rs1_val < rs2_val);
         br_geu:  cond_true = (rs1_val >= rs2_val);
         default: cond_true = 1'b0;
      endcase
   end

   assign is_cf = ctrl.is_branch | ctrl.is_jump | ctrl.is_jumpr;
   assign taken = ctrl.is_jump | ctrl.is_jumpr | (ctrl.is_branch & cond_true);

   assign jalr_sum = rs1_val + imm;
   assign target   = ctrl.is_jumpr ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;
   assign link_pc  = pc + 32'd4;

   // Wrong direction, or right direction to the wrong place
   assign mispredict = is_cf &
                       ((taken != pred.pred_taken) ||
                        (taken && (target != pred.pred_target)));

   // Only conditional branches shift the history
   assign update_ghsr  = ctrl.is_branch;
   assign ghsr_restore = {pred.ghsr[ghsr_width-2:0], taken};

endmodule

`default_nettype wire

// File: design/ex_lsu_agen.sv
`default_nettype none

module ex_lsu_agen (
   input  wire ex_pkg::ex_ctrl_t        ctrl,
   input  wire logic [ex_pkg::xlen-1:0] rs1_val,
   input  wire logic [ex_pkg::xlen-1:0] rs2_val,
   input  wire logic [ex_pkg::xlen-1:0] imm,
   output logic [ex_pkg::xlen-1:0]      mem_addr,
   output logic [ex_pkg::xlen-1:0]      store_data,
   output logic [3:0]                   byte_en,
   output logic                         misaligned
);
   import ex_pkg::*;

   logic            mem_op;
   logic [3:0]      lane_mask;
   logic [xlen-1:0] lane_data;
   logic            bad_align;

   assign mem_addr = rs1_val + imm;
   assign mem_op   = ctrl.mem_read | ctrl.mem_write;

   always_comb begin
      case (ctrl.mem_size)
         mem_byte: begin
            lane_mask = 4'b0001 << mem_addr[1:0];
            lane_data = {4{rs2_val[7:0]}};
            bad_align = 1'b0;
         end
         mem_half: begin
            lane_mask = 4'b0011 << {mem_addr[1], 1'b0};
            lane_data = {2{rs2_val[15:0]}};
            bad_align = mem_addr[0];
         end
         default: begin   // Word
            lane_mask = 4'b1111;
            lane_data = rs2_val;
            bad_align = |mem_addr[1:0];
         end
      endcase
   end

   assign byte_en    = mem_op ? lane_mask : 4'b0000;
   assign store_data = ctrl.mem_write ? lane_data : '0;   // Memory picks lanes by byte_en
   assign misaligned = mem_op & bad_align;

endmodule

`default_nettype wire

// File: design/ex_ctrl.sv
`default_nettype none

module ex_ctrl #(
   parameter int n_credits = 4
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         in_valid,
   output logic                              in_ready,
   input  wire logic                         credit_ret,
   input  wire ex_pkg::ex_ctrl_t             ctrl,
   input  wire logic [ex_pkg::xlen-1:0]      pc,
   input  wire logic [ex_pkg::xlen-1:0]      alu_data,
   input  wire logic [ex_pkg::xlen-1:0]      link_pc,
   input  wire logic [ex_pkg::xlen-1:0]      mem_addr,
   input  wire logic [ex_pkg::xlen-1:0]      store_data,
   input  wire logic [3:0]                   byte_en,
   input  wire logic                         misaligned,
   input  wire logic                         br_taken,
   input  wire logic [ex_pkg::xlen-1:0]      br_target,
   input  wire logic                         mispredict,
   input  wire logic                         update_ghsr,
   input  wire logic [ex_pkg::ghsr_width-1:0] ghsr_restore,
   output logic                              out_valid,
   output ex_pkg::ex_result_t                out_result,
   output ex_pkg::br_redirect_t              redirect
);

   localparam int cnt_w = $clog2(n_credits + 1);

   logic [cnt_w-1:0]        credits;
   logic                    accept;
   logic                    is_cf;
   logic [$bits(pc)-1:0]    rd_data;

   assign in_ready = (credits != '0);
   assign accept   = in_valid & in_ready;
   assign is_cf    = ctrl.is_branch | ctrl.is_jump | ctrl.is_jumpr;

   always_comb begin
      if (ctrl.is_jump | ctrl.is_jumpr) begin
         rd_data = link_pc;
      end else if (ctrl.mem_read | ctrl.mem_write) begin
         rd_data = mem_addr;   // Address goes down the pipe as rd_data
      end else begin
         rd_data = alu_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= cnt_w'(n_credits);
      end else if (accept && !credit_ret) begin
         credits <= credits - 1'b1;
      end else if (credit_ret && !accept) begin
         credits <= credits + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid      <= 1'b0;
         redirect.valid <= 1'b0;
      end else begin
         out_valid      <= accept;
         redirect.valid <= accept & is_cf;
         if (accept) begin
            out_result.ctrl       <= ctrl;
            out_result.rd_data    <= rd_data;
            out_result.mem_addr   <= mem_addr;
            out_result.store_data <= store_data;
            out_result.byte_en    <= byte_en;
            out_result.misaligned <= misaligned;
            redirect.taken        <= br_taken;
            redirect.mispredict   <= mispredict;
            redirect.branch_pc    <= pc;
            redirect.target       <= br_target;
            redirect.update_ghsr  <= update_ghsr;
            redirect.ghsr_restore <= ghsr_restore;
         end
      end
   end

   a_credit_max: assert property (@(posedge clk) disable iff (rst)
      credits <= cnt_w'(n_credits));

   // Downstream can only return what it was given
   a_no_extra_credit: assert property (@(posedge clk) disable iff (rst)
      credit_ret |-> (credits < cnt_w'(n_credits)));

   a_valid_after_accept: assert property (@(posedge clk) disable iff (rst)
      $rose(out_valid) |-> $past(accept));

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`default_nettype none

module ex_stage #(
   parameter int n_credits = 4
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    in_valid,
   output logic                         in_ready,
   input  wire ex_pkg::ex_op_t          in_op,
   input  wire ex_pkg::br_pred_t        in_pred,
   input  wire logic [ex_pkg::xlen-1:0] fwd_ex_mem,
   input  wire logic [ex_pkg::xlen-1:0] fwd_mem_wb,
   output logic                         out_valid,
   output ex_pkg::ex_result_t           out_result,
   input  wire logic                    credit_ret,
   output ex_pkg::br_redirect_t         redirect
);
   import ex_pkg::*;

   logic [xlen-1:0]       rs1_val;
   logic [xlen-1:0]       rs2_val;
   logic [xlen-1:0]       alu_a;
   logic [xlen-1:0]       alu_b;
   logic [xlen-1:0]       alu_data;
   logic                  br_taken;
   logic [xlen-1:0]       link_pc;
   logic [xlen-1:0]       br_target;
   logic                  mispredict;
   logic                  update_ghsr;
   logic [ghsr_width-1:0] ghsr_restore;
   logic [xlen-1:0]       mem_addr;
   logic [xlen-1:0]       store_data;
   logic [3:0]            byte_en;
   logic                  misaligned;

   ex_operand_sel operand_sel_i (
      .clk        (clk),
      .rst        (rst),
      .op         (in_op),
      .fwd_ex_mem (fwd_ex_mem),
      .fwd_mem_wb (fwd_mem_wb),
      .rs1_val    (rs1_val),
      .rs2_val    (rs2_val),
      .alu_a      (alu_a),
      .alu_b      (alu_b)
   );

   ex_alu alu_i (
      .op     (in_op.ctrl.alu_op),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_data)
   );

   // Compares use forwarded registers, not the ALU operands
   ex_branch_unit branch_unit_i (
      .ctrl         (in_op.ctrl),
      .pc           (in_op.pc),
      .imm          (in_op.imm),
      .rs1_val      (rs1_val),
      .rs2_val      (rs2_val),
      .pred         (in_pred),
      .taken        (br_taken),
      .link_pc      (link_pc),
      .target       (br_target),
      .mispredict   (mispredict),
      .update_ghsr  (update_ghsr),
      .ghsr_restore (ghsr_restore)
   );

   ex_lsu_agen lsu_agen_i (
      .ctrl       (in_op.ctrl),
      .rs1_val    (rs1_val),
      .rs2_val    (rs2_val),
      .imm        (in_op.imm),
      .mem_addr   (mem_addr),
      .store_data (store_data),
      .byte_en    (byte_en),
      .misaligned (misaligned)
   );

   ex_ctrl #(
      .n_credits (n_credits)
   ) ctrl_i (
      .clk          (clk),
      .rst          (rst),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .credit_ret   (credit_ret),
      .ctrl         (in_op.ctrl),
      .pc           (in_op.pc),
      .alu_data     (alu_data),
      .link_pc      (link_pc),
      .mem_addr     (mem_addr),
      .store_data   (store_data),
      .byte_en      (byte_en),
      .misaligned   (misaligned),
      .br_taken     (br_taken),
      .br_target    (br_target),
      .mispredict   (mispredict),
      .update_ghsr  (update_ghsr),
      .ghsr_restore (ghsr_restore),
      .out_valid    (out_valid),
      .out_result   (out_result),
      .redirect     (redirect)
   );

endmodule

`default_nettype wire

// File: tests/ex_stage_tb.sv
`default_nettype none

module ex_stage_tb;
   import ex_pkg::*;

   localparam int n_credits = 4;
   localparam int max_wait  = 400;

   logic            clk = 1'b0;
   logic            rst = 1'b1;
   logic            in_valid = 1'b0;
   logic            in_ready;
   ex_op_t          in_op = '0;
   br_pred_t        in_pred = '0;
   logic [xlen-1:0] fwd_ex_mem = '0;
   logic [xlen-1:0] fwd_mem_wb = '0;
   logic            out_valid;
   ex_result_t      out_result;
   logic            credit_ret = 1'b0;
   br_redirect_t    redirect;

   ex_result_t   exp_q[$];     // Expected results in acceptance order
   br_redirect_t redir_q[$];
   ex_result_t   exp_res = '0;  // Head of the queue for the assertions
   br_redirect_t exp_redir = '0;
   logic         exp_cf = 1'b0;
   int           exp_count = 0;
   int           model_credits = n_credits;
   logic         acc_d = 1'b0;
   logic         rst_d = 1'b1;
   int           cyc = 0;
   int           ret_q[$];      // Cycle at which each credit goes back
   logic         stall_down = 1'b0;
   int           errors = 0;
   int           tests_failed = 0;
   int           tests_run = 0;

   ex_stage #(.n_credits(n_credits)) ex_stage_i (
      .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
      .in_op(in_op), .in_pred(in_pred), .fwd_ex_mem(fwd_ex_mem),
      .fwd_mem_wb(fwd_mem_wb), .out_valid(out_valid), .out_result(out_result),
      .credit_ret(credit_ret), .redirect(redirect)
   );

   always #2 clk = ~clk;

   task automatic report_mismatch(input string sig, input logic [31:0] e, input logic [31:0] a);
      $display("ERROR time %0t %s expected %h actual %h", $time, sig, e, a);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("Failure at time %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic abort_run(input string msg);
      $display("Timeout at time %0t: %s", $time, msg);
      $display("tests failed");
      $finish;
   endtask

   // Reference model of the execute stage
   function automatic void model_op(input ex_op_t op, input br_pred_t p,
                                    input logic [31:0] fe, input logic [31:0] fm,
                                    output ex_result_t r, output br_redirect_t d);
      logic [31:0] r1, r2, a, b, alu, addr;
      logic        cond;
      r1 = (op.fwd_sel_rs1 == fwd_from_mem_wb) ? fm :
           (op.fwd_sel_rs1 == fwd_from_ex_mem) ? fe : op.rs1_data;
      r2 = (op.fwd_sel_rs2 == fwd_from_mem_wb) ? fm :
           (op.fwd_sel_rs2 == fwd_from_ex_mem) ? fe : op.rs2_data;
      a = op.ctrl.is_auipc ? op.pc : r1;
      b = op.ctrl.alu_src_imm ? op.imm : r2;
      case (op.ctrl.alu_op)
         alu_add:  alu = a + b;
         alu_sub:  alu = a - b;
         alu_sll:  alu = a << b[4:0];
         alu_slt:  alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         alu_sltu: alu = (a < b) ? 32'd1 : 32'd0;
         alu_xor:  alu = a ^ b;
         alu_srl:  alu = a >> b[4:0];
         alu_sra:  alu = 32'($signed(a) >>> b[4:0]);
         alu_or:   alu = a | b;
         alu_and:  alu = a & b;
         default:  alu = b;
      endcase
      addr = r1 + op.imm;
      r = '0;
      r.ctrl = op.ctrl;
      r.mem_addr = addr;
      if (op.ctrl.is_jump || op.ctrl.is_jumpr) r.rd_data = op.pc + 32'd4;
      else if (op.ctrl.mem_read || op.ctrl.mem_write) r.rd_data = addr;
      else r.rd_data = alu;
      if (op.ctrl.mem_read || op.ctrl.mem_write) begin
         case (op.ctrl.mem_size)
            mem_byte: begin
               r.byte_en = 4'b0001 << addr[1:0];
               r.store_data = {4{r2[7:0]}};
            end
            mem_half: begin
               r.byte_en = addr[1] ? 4'b1100 : 4'b0011;
               r.store_data = {2{r2[15:0]}};
               r.misaligned = addr[0];
            end
            default: begin
               r.byte_en = 4'b1111;
               r.store_data = r2;
               r.misaligned = (addr[1:0] != 2'b00);
            end
         endcase
      end
      case (op.ctrl.br_cond)
         br_eq:   cond = (r1 == r2);
         br_ne:   cond = (r1 != r2);
         br_lt:   cond = ($signed(r1) < $signed(r2));
         br_ge:   cond = ($signed(r1) >= $signed(r2));
         br_ltu:  cond = (r1 < r2);
         default: cond = (r1 >= r2);
      endcase
      d = '0;
      d.valid = op.ctrl.is_branch | op.ctrl.is_jump | op.ctrl.is_jumpr;
      d.taken = op.ctrl.is_jump | op.ctrl.is_jumpr | (op.ctrl.is_branch & cond);
      d.branch_pc = op.pc;
      d.target = op.ctrl.is_jumpr ? ((r1 + op.imm) & ~32'd1) : op.pc + op.imm;
      d.mispredict = d.valid & ((d.taken != p.pred_taken) ||
                                (d.taken && d.target != p.pred_target));
      d.update_ghsr = op.ctrl.is_branch;
      d.ghsr_restore = {p.ghsr[6:0], d.taken};
   endfunction

   function automatic logic [31:0] rand_imm();
      logic [31:0] v;
      v = $urandom;
      case ($urandom % 4)
         0:       return v % 16;
         1:       return -(v % 16);
         2:       return {v[19:0], 12'h000};   // LUI/AUIPC style
         default: return v;
      endcase
   endfunction

   task automatic gen_op(input int kind, output ex_op_t op, output br_pred_t p,
                         output logic [31:0] fe, output logic [31:0] fm);
      ex_result_t   r;
      br_redirect_t d;
      int           sel;
      op = '0;
      op.pc = $urandom & 32'hffff_fffc;
      op.rs1_data = $urandom;
      op.rs2_data = ($urandom % 4 == 0) ? op.rs1_data : $urandom;
      op.imm = rand_imm();
      op.fwd_sel_rs1 = fwd_sel_e'($urandom % 3);
      op.fwd_sel_rs2 = fwd_sel_e'($urandom % 3);
      op.ctrl.rd_addr = 5'($urandom % 32);
      op.ctrl.rd_write = 1'b1;
      fe = $urandom;
      fm = $urandom;
      p = '0;
      p.ghsr = 8'($urandom);
      if (kind == 0) begin
         op.ctrl.alu_op = alu_op_e'($urandom % 11);
         op.ctrl.alu_src_imm = 1'($urandom % 2);
         if (op.ctrl.alu_op == alu_add && $urandom % 3 == 0) op.ctrl.is_auipc = 1'b1;
         if (op.ctrl.alu_op == alu_pass_b || op.ctrl.is_auipc) op.ctrl.alu_src_imm = 1'b1;
      end else if (kind == 1) begin
         sel = $urandom % 8;
         if (sel < 6) begin
            op.ctrl.is_branch = 1'b1;
            op.ctrl.br_cond = br_cond_e'(sel);
            op.ctrl.rd_write = 1'b0;
            op.imm = op.imm & ~32'd1;
         end else if (sel == 6) op.ctrl.is_jump = 1'b1;
         else op.ctrl.is_jumpr = 1'b1;
         model_op(op, p, fe, fm, r, d);
         if ($urandom % 2 == 0) begin   // Correct prediction
            p.pred_taken = d.taken;
            p.pred_target = d.target;
         end else begin
            p.pred_taken = 1'($urandom % 2);
            p.pred_target = ($urandom % 2 == 0) ? d.target : d.target + 32'd4;
         end
      end else begin
         op.ctrl.mem_write = 1'($urandom % 2);
         op.ctrl.mem_read = ~op.ctrl.mem_write;
         op.ctrl.mem_size = mem_size_e'($urandom % 3);
         op.ctrl.load_unsigned = 1'($urandom % 2);
         op.imm = ($urandom % 16) - 32'd8;
      end
   endtask

   // Scoreboard bookkeeping
   always @(posedge clk) begin
      ex_result_t   r;
      br_redirect_t d;
      logic         acc;
      int           crd;
      if (rst) begin
         exp_q.delete();
         redir_q.delete();
         crd = n_credits;
         acc = 1'b0;
      end else begin
         if (out_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            void'(redir_q.pop_front());
         end
         crd = model_credits;
         if (credit_ret) crd++;
         acc = in_valid && in_ready;
         if (acc) begin
            model_op(in_op, in_pred, fwd_ex_mem, fwd_mem_wb, r, d);
            exp_q.push_back(r);
            redir_q.push_back(d);
            crd--;
         end
      end
      model_credits <= crd;
      acc_d <= acc;
      rst_d <= rst;
      exp_count <= exp_q.size();
      if (exp_q.size() > 0) begin
         exp_res <= exp_q[0];
         exp_redir <= redir_q[0];
         exp_cf <= redir_q[0].valid;
      end
   end

   // Downstream stage retires results after 0 to 6 cycles
   always @(posedge clk) begin
      logic ret;
      int   due;
      cyc++;
      if (!rst && out_valid) begin
         due = cyc + ($urandom % 7);
         if (ret_q.size() > 0 && due <= ret_q[ret_q.size()-1]) due = ret_q[ret_q.size()-1] + 1;
         ret_q.push_back(due);
      end
      ret = !rst && !stall_down && ret_q.size() > 0 && ret_q[0] <= cyc;
      if (ret) void'(ret_q.pop_front());
      #1 credit_ret = ret;
   end

   a_idle_after_reset: assert property (@(posedge clk)
      (rst_d && !rst) |-> (in_ready && !out_valid && !redirect.valid))
      else report_failure("stage not idle right after reset");
   a_ready_credits: assert property (@(posedge clk) disable iff (rst)
      in_ready == (model_credits != 0))
      else report_mismatch("in_ready", 32'($sampled(model_credits) != 0), 32'($sampled(in_ready)));
   a_valid_has_accept: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> acc_d)
      else report_failure("out_valid without an acceptance one cycle earlier");
   a_valid_has_expected: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> exp_count > 0)
      else report_failure("result appeared with nothing outstanding");
   a_ctrl: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> out_result.ctrl == exp_res.ctrl)
      else report_mismatch("ctrl", 32'($sampled(exp_res.ctrl)),
                           32'($sampled(out_result.ctrl)));
   a_rd_data: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> out_result.rd_data == exp_res.rd_data)
      else report_mismatch("rd_data", $sampled(exp_res.rd_data), $sampled(out_result.rd_data));
   a_mem_addr: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> out_result.mem_addr == exp_res.mem_addr)
      else report_mismatch("mem_addr", $sampled(exp_res.mem_addr), $sampled(out_result.mem_addr));
   a_byte_en: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> out_result.byte_en == exp_res.byte_en)
      else report_mismatch("byte_en", 32'($sampled(exp_res.byte_en)),
                           32'($sampled(out_result.byte_en)));
   a_misaligned: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> out_result.misaligned == exp_res.misaligned)
      else report_mismatch("misaligned", 32'($sampled(exp_res.misaligned)),
                           32'($sampled(out_result.misaligned)));
   a_store_data: assert property (@(posedge clk) disable iff (rst)
      (out_valid && exp_res.ctrl.mem_write) |-> out_result.store_data == exp_res.store_data)
      else report_mismatch("store_data", $sampled(exp_res.store_data),
                           $sampled(out_result.store_data));
   a_redir_valid: assert property (@(posedge clk) disable iff (rst)
      redirect.valid == (out_valid && exp_cf))
      else report_mismatch("redirect.valid", 32'($sampled(out_valid && exp_cf)),
                           32'($sampled(redirect.valid)));
   a_redir_taken: assert property (@(posedge clk) disable iff (rst)
      (redirect.valid && exp_cf) |-> redirect.taken == exp_redir.taken)
      else report_mismatch("redirect.taken", 32'($sampled(exp_redir.taken)),
                           32'($sampled(redirect.taken)));
   a_redir_branch_pc: assert property (@(posedge clk) disable iff (rst)
      (redirect.valid && exp_cf) |-> redirect.branch_pc == exp_redir.branch_pc)
      else report_mismatch("redirect.branch_pc", $sampled(exp_redir.branch_pc),
                           $sampled(redirect.branch_pc));
   a_redir_target: assert property (@(posedge clk) disable iff (rst)
      (redirect.valid && exp_cf) |-> redirect.target == exp_redir.target)
      else report_mismatch("redirect.target", $sampled(exp_redir.target),
                           $sampled(redirect.target));
   a_redir_mispredict: assert property (@(posedge clk) disable iff (rst)
      (redirect.valid && exp_cf) |-> redirect.mispredict == exp_redir.mispredict)
      else report_mismatch("redirect.mispredict", 32'($sampled(exp_redir.mispredict)),
                           32'($sampled(redirect.mispredict)));
   a_update_ghsr: assert property (@(posedge clk) disable iff (rst)
      (redirect.valid && exp_cf) |-> redirect.update_ghsr == exp_redir.update_ghsr)
      else report_mismatch("redirect.update_ghsr", 32'($sampled(exp_redir.update_ghsr)),
                           32'($sampled(redirect.update_ghsr)));
   a_ghsr_restore: assert property (@(posedge clk) disable iff (rst)
      (redirect.valid && exp_redir.update_ghsr) |->
      redirect.ghsr_restore == exp_redir.ghsr_restore)
      else report_mismatch("redirect.ghsr_restore", 32'($sampled(exp_redir.ghsr_restore)),
                           32'($sampled(redirect.ghsr_restore)));

   task automatic send_op(input ex_op_t op, input br_pred_t p,
                          input logic [31:0] fe, input logic [31:0] fm);
      int n;
      n = 0;
      in_op = op;
      in_pred = p;
      fwd_ex_mem = fe;
      fwd_mem_wb = fm;
      in_valid = 1'b1;
      while (!in_ready) begin   // Hold the op until a credit frees up
         @(posedge clk);
         #1;
         n++;
         if (n > max_wait) abort_run("in_ready never rose");
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 || ret_q.size() != 0 || model_credits != n_credits) begin
         @(posedge clk);
         #1;
         n++;
         if (n > max_wait) abort_run("results or credits never drained");
      end
   endtask

   task automatic finish_test(input string name, input int e0);
      tests_run++;
      if (errors != e0) tests_failed++;
      $display("test %s: %s", name, (errors == e0) ? "ok" : "FAILED");
   endtask

   // Kind 3 picks a random kind for every op
   task automatic run_ops(input string name, input int kind, input int count);
      ex_op_t      op;
      br_pred_t    p;
      logic [31:0] fe, fm;
      int          e0;
      e0 = errors;
      for (int i = 0; i < count; i++) begin
         gen_op((kind > 2) ? int'($urandom % 3) : kind, op, p, fe, fm);
         send_op(op, p, fe, fm);
      end
      wait_drain();
      finish_test(name, e0);
   endtask

   task automatic credit_test();
      ex_op_t      op;
      br_pred_t    p;
      logic [31:0] fe, fm;
      logic        rdy;
      int          accepted, e0;
      e0 = errors;
      accepted = 0;
      stall_down = 1'b1;
      gen_op(0, op, p, fe, fm);
      in_op = op;
      in_pred = p;
      in_valid = 1'b1;
      for (int i = 0; i < 3 * n_credits; i++) begin
         rdy = in_ready;
         @(posedge clk);
         #1;
         if (rdy) begin
            accepted++;
            gen_op(0, op, p, fe, fm);
            in_op = op;
            in_pred = p;
            fwd_ex_mem = fe;
            fwd_mem_wb = fm;
         end
      end
      a_stall_count: assert (accepted == n_credits && !in_ready)
         else report_mismatch("accepted", n_credits, accepted);
      in_valid = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      stall_down = 1'b0;
      wait_drain();
      finish_test("credit flow", e0);
   endtask

   initial begin
      int e0;
      void'($urandom(14));
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      e0 = errors;
      repeat (3) @(posedge clk);
      #1;
      finish_test("reset and idle", e0);
      run_ops("alu", 0, 300);
      run_ops("branch and jump", 1, 300);
      run_ops("load and store", 2, 300);
      credit_test();
      run_ops("mixed after stall", 3, 50);
      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: ex_stage.f
design/ex_pkg.sv
design/ex_operand_sel.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_lsu_agen.sv
design/ex_ctrl.sv
design/ex_stage.sv
tests/ex_stage_tb.sv

// File: Makefile
SRCS := $(shell cat ex_stage.f)

.PHONY: run clean

obj_dir/Vex_stage_tb: $(SRCS) ex_stage.f
	verilator --binary --timing --assert -Wno-fatal --top-module ex_stage_tb -f ex_stage.f

run: obj_dir/Vex_stage_tb
	./obj_dir/Vex_stage_tb | tee sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
